/* bench/uart_intr_chk.sv */
// UART interrupt block checker
// Concurrent assertions on IIR, INT, RDATA and the THR-empty latch

`default_nettype none

`include "uart_params.svh"

module uart_intr_chk (
    input logic                    CLK,
    input logic                    RST,
    input logic                    INT,
    input logic [`UART_IIR_W-1:0]  iir,
    input logic [`UART_DATA_W-1:0] RDATA,
    input logic                    thri,
    input logic                    thrWrite,
    input logic                    iirRead
);
    timeunit 1ns;
    timeprecision 100ps;

    int failCount = 0;      // Assertion failures so far

    intMatch: assert property (@(posedge CLK) disable iff (RST) INT == ~iir[0])
        else begin
            failCount++;
            $error("INT differs from inverted IIR bit 0");
        end

    // Six codes only
    iirLegal: assert property (@(posedge CLK) disable iff (RST)
        iir inside {`UART_IIR_NONE, `UART_IIR_RLS, `UART_IIR_CTI,
                    `UART_IIR_RDA, `UART_IIR_THR, `UART_IIR_MSR})
        else begin
            failCount++;
            $error("Illegal IIR code %b", iir);
        end

    rdataReset: assert property (@(posedge CLK) RST |-> RDATA == '0)
        else begin
            failCount++;
            $error("RDATA not zero during reset");
        end

    thriFall: assert property (@(posedge CLK) disable iff (RST)
        $fell(thri) |-> $past(thrWrite || iirRead))     // Ack edge one cycle back
        else begin
            failCount++;
            $error("THR-empty latch dropped without an ack");
        end

endmodule

bind uart_intr_top uart_intr_chk uChk (
    .CLK(CLK), .RST(RST), .INT(INT), .iir(iir), .RDATA(RDATA),
    .thri(thri), .thrWrite(thrWrite), .iirRead(iirRead)
);

`default_nettype wire

/* bench/uart_intr_tb.sv */
// UART interrupt block testbench
// Drives the host bus, modem pins and status levels, keeps a model
// of the sticky, delta and THR-empty state and checks the DUT against it

`default_nettype none

`include "uart_params.svh"

module uart_intr_tb;
    timeunit 1ns;
    timeprecision 100ps;

    logic        CLK, RST, WR, RD, INT;
    logic [2:0]  ADDR;
    logic [7:0]  WDATA, RDATA;
    logic        CTSn, DSRn, RIn, DCDn;
    logic        RDA, CTI, THREMPTY, AFE;
    logic        ERROVR, ERRPAR, ERRFRM, ERRBRK;
    logic [3:0]  pinN;          // Active-low modem pins {dcd, ri, dsr, cts}
    logic [3:0]  mIer;          // Model IER
    logic [3:0]  mErr;          // Sticky {brk, frm, par, ovr}
    logic [3:0]  mDelta;        // {dDcd, teri, dDsr, dCts}
    logic        mThri;         // THR-empty latch
    logic [3:0]  cmpIir;
    logic [31:0] lcgState;
    int          errCount, checkCount, testErrBase;
    event        settleEv;

    assign {DCDn, RIn, DSRn, CTSn} = pinN;

    uart_intr_top u_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;  // 8 ns period
    end

    function automatic logic [31:0] lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Expected IIR by priority RLS, CTI, RDA, THR, MSR
    function automatic logic [3:0] refIir(input logic [3:0] ien, input logic [3:0] err,
            input logic [3:0] dlt, input logic thr, input logic rda, input logic cti,
            input logic afe);
        logic msrAny;
        msrAny = (dlt[0] && !afe) || dlt[1] || dlt[2] || dlt[3];  // dCts masked by AFE
        if (ien[2] && (err != 4'b0000)) return `UART_IIR_RLS;
        if (ien[0] && cti) return `UART_IIR_CTI;
        if (ien[0] && rda) return `UART_IIR_RDA;
        if (ien[1] && thr) return `UART_IIR_THR;
        if (ien[3] && msrAny) return `UART_IIR_MSR;
        return `UART_IIR_NONE;
    endfunction

    function automatic logic [3:0] expIir();
        return refIir(mIer, mErr, mDelta, mThri, RDA, CTI, AFE);
    endfunction

    task automatic checkVal(input string name, input logic [7:0] exp, input logic [7:0] act);
        checkCount++;
        assert (act === exp) else begin
            errCount++;
            $display("Error at %0t: %s expected %02h, got %02h", $time, name, exp, act);
        end
    endtask

    task automatic writeReg(input logic [2:0] addr, input logic [7:0] data);
        @(negedge CLK);
        WR    = 1'b1;
        ADDR  = addr;
        WDATA = data;
        @(negedge CLK);
        WR = 1'b0;
        @(posedge CLK);                                 // Register update edge
        if (addr == `UART_ADDR_IER) mIer = data[3:0];
        if (addr == `UART_ADDR_THR) mThri = 1'b0;       // Write acks THR empty
    endtask

    task automatic readReg(input logic [2:0] addr, output logic [7:0] data);
        @(negedge CLK);
        RD   = 1'b1;
        ADDR = addr;
        @(negedge CLK);
        RD = 1'b0;
        @(negedge CLK);         // RDATA latched on the second rising edge
        data = RDATA;
    endtask

    // Long enough for a pin change to reach the IIR
    task automatic settle();
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        -> settleEv;
    endtask

    task automatic waitInt(input logic level, input int limit);
        int n;
        n = 0;
        while (INT !== level && n < limit) begin
            @(negedge CLK);
            n++;
        end
        assert (INT === level) else begin
            errCount++;
            $display("Timeout: INT did not go to %0b within %0d cycles", level, limit);
        end
    endtask

    task automatic errPulse(input logic [3:0] bits);
        @(negedge CLK);
        {ERRBRK, ERRFRM, ERRPAR, ERROVR} = bits;
        @(negedge CLK);
        {ERRBRK, ERRFRM, ERRPAR, ERROVR} = 4'b0000;
        mErr = mErr | bits;
    endtask

    task automatic setPin(input int idx, input logic level);
        @(negedge CLK);
        if (idx == 2) mDelta[2] = mDelta[2] | (!pinN[2] && level);     // RI released
        else mDelta[idx] = mDelta[idx] | (pinN[idx] != level);
        pinN[idx] = level;
    endtask

    task automatic setThrEmpty(input logic level);
        @(negedge CLK);
        mThri = mThri | (level && !THREMPTY);   // Rising edge only
        THREMPTY = level;
    endtask

    task automatic checkIir();
        logic [3:0] exp;
        logic [7:0] d;
        settle();
        exp = expIir();
        readReg(`UART_ADDR_IIR, d);
        checkVal("IIR", {`UART_IIR_FIFO, exp}, d);
        if (exp == `UART_IIR_THR) mThri = 1'b0;     // Shown THR code is acked
    endtask

    task automatic readLsr();
        logic [7:0] d;
        logic [7:0] exp;
        exp = {1'b0, THREMPTY, THREMPTY, mErr, RDA};
        readReg(`UART_ADDR_LSR, d);
        checkVal("LSR", exp, d);
        mErr = 4'b0000;
    endtask

    task automatic readMsr();
        logic [7:0] d;
        logic [7:0] exp;
        exp = {~pinN, mDelta};
        readReg(`UART_ADDR_MSR, d);
        checkVal("MSR", exp, d);
        mDelta = 4'b0000;
    endtask

    task automatic endTest(input string name);
        $display("%s: %0d errors", name, errCount - testErrBase);
        testErrBase = errCount;
    endtask

    // INT against the model after every settle
    always @(settleEv) begin
        cmpIir = expIir();
        checkCount++;
        assert (INT === ~cmpIir[0]) else begin
            errCount++;
            $display("Error at %0t: INT expected %0b, got %0b", $time, ~cmpIir[0], INT);
        end
    end

    initial begin
        logic [7:0]  d;
        logic [31:0] rnd;
        RST = 1'b1;
        {WR, RD, ADDR, WDATA} = '0;
        {RDA, CTI, THREMPTY, AFE} = 4'b0000;
        {ERRBRK, ERRFRM, ERRPAR, ERROVR} = 4'b0000;
        pinN = 4'hF;                    // All pins inactive
        {mIer, mErr, mDelta, mThri} = '0;
        lcgState = 32'd45469;
        {errCount, checkCount, testErrBase} = '0;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b0;

        checkVal("INT", 8'h00, {7'd0, INT});
        readReg(`UART_ADDR_IIR, d);
        checkVal("IIR", 8'hC1, d);
        readReg(`UART_ADDR_IER, d);
        checkVal("IER", 8'h00, d);
        endTest("test 1 reset values");

        // Add sources lowest first, then take them away
        writeReg(`UART_ADDR_IER, 8'h0F);
        checkIir();
        setPin(1, 1'b0);
        checkIir();
        setThrEmpty(1'b1);
        checkIir();
        @(negedge CLK);
        RDA = 1'b1;
        checkIir();
        @(negedge CLK);
        CTI = 1'b1;
        checkIir();
        errPulse(4'b0010);
        checkIir();
        readLsr();
        checkIir();
        @(negedge CLK);
        CTI = 1'b0;
        checkIir();
        @(negedge CLK);
        RDA = 1'b0;
        checkIir();
        writeReg(`UART_ADDR_THR, 8'h5A);
        checkIir();
        readMsr();
        checkIir();
        endTest("test 2 priority");

        writeReg(`UART_ADDR_IER, 8'h04);
        for (int i = 0; i < 4; i++) begin
            errPulse(4'b0001 << i);
            waitInt(1'b1, 8);
            readLsr();                  // Bit set
            readLsr();                  // Bit gone
            waitInt(1'b0, 8);
            settle();
        end
        endTest("test 3 sticky errors");

        writeReg(`UART_ADDR_IER, 8'h08);
        for (int i = 0; i < 4; i++) begin
            if (i == 2) begin
                setPin(2, 1'b0);        // Ring start without a delta
                settle();
            end
            setPin(i, ~pinN[i]);
            waitInt(1'b1, 12);
            readMsr();
            waitInt(1'b0, 12);
        end
        @(negedge CLK);
        AFE = 1'b1;
        setPin(0, ~pinN[0]);            // dCts without interrupt
        settle();
        readMsr();
        @(negedge CLK);
        AFE = 1'b0;
        checkIir();
        endTest("test 4 modem status");

        writeReg(`UART_ADDR_IER, 8'h03);
        setThrEmpty(1'b0);
        setThrEmpty(1'b1);
        checkIir();                     // THR shown and acked
        checkIir();
        setThrEmpty(1'b0);
        setThrEmpty(1'b1);
        writeReg(`UART_ADDR_THR, 8'hA5);
        checkIir();
        setThrEmpty(1'b0);
        setThrEmpty(1'b1);
        @(negedge CLK);
        RDA = 1'b1;
        checkIir();                     // RDA hides THR and the latch stays
        @(negedge CLK);
        RDA = 1'b0;
        checkIir();
        checkIir();
        endTest("test 5 THR empty");

        for (int i = 0; i < 200; i++) begin
            rnd = lcgNext();
            if (rnd[20]) readLsr();
            if (rnd[21]) readMsr();
            if (rnd[22]) writeReg(`UART_ADDR_THR, rnd[15:8]);
            if (rnd[23]) setPin(rnd[25:24], ~pinN[rnd[25:24]]);
            setThrEmpty(rnd[29]);
            RDA = rnd[26];
            CTI = rnd[27];
            AFE = rnd[28];
            if (rnd[30]) errPulse(rnd[19:16]);
            writeReg(`UART_ADDR_IER, {4'h0, rnd[11:8]});
            checkIir();
        end
        endTest("test 6 random mix");

        errCount += u_dut.uChk.failCount;
        $display("%0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/uart_host_if.sv */
// UART host interface
// Registers the one-cycle bus strobes and turns them into
// per-register access pulses one cycle later, holds IER

`default_nettype none

`include "uart_params.svh"

module uart_host_if (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    WR,         // Write strobe
    input  logic                    RD,         // Read strobe
    input  logic [`UART_ADDR_W-1:0] ADDR,
    input  logic [`UART_DATA_W-1:0] WDATA,      // Upper nibble unused
    output logic [`UART_IER_W-1:0]  ier,
    output logic                    thrWrite,   // THR write event
    output logic                    iirRead,
    output logic                    lsrRead,
    output logic                    msrRead,
    output logic                    rdEn,       // Any read, any address
    output logic [`UART_ADDR_W-1:0] rdAddr
);

    logic                    wrQ;       // Registered write strobe
    logic                    rdQ;       // Registered read strobe
    logic [`UART_ADDR_W-1:0] addrQ;
    logic [`UART_IER_W-1:0]  wdataQ;    // Only IER bits matter

    // Strobe stage
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            wrQ   <= 1'b0;
            rdQ   <= 1'b0;
            addrQ <= '0;
        end else begin
            wrQ   <= WR;
            rdQ   <= RD & ~WR;              // Collision counts as write
            addrQ <= ADDR;
        end
    end

    always_ff @(posedge CLK) begin
        wdataQ <= WDATA[`UART_IER_W-1:0];   // THR data dropped
    end

    // Access pulses, one cycle after the strobe
    assign thrWrite = wrQ && (addrQ == `UART_ADDR_THR);
    assign iirRead  = rdQ && (addrQ == `UART_ADDR_IIR);
    assign lsrRead  = rdQ && (addrQ == `UART_ADDR_LSR);
    assign msrRead  = rdQ && (addrQ == `UART_ADDR_MSR);
    assign rdEn     = rdQ;
    assign rdAddr   = addrQ;

    // Interrupt enable register
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            ier <= `UART_IER_RST;
        end else if (wrQ && (addrQ == `UART_ADDR_IER)) begin
            ier <= wdataQ;                  // Lands one cycle after WR
        end
    end

endmodule

`default_nettype wire

/* src/uart_interrupt.sv */
// UART interrupt identification
// Masks the five sources with IER and registers the code of
// the highest-priority one as the IIR, drives INT from it

`default_nettype none

`include "uart_params.svh"

module uart_interrupt (
    input  logic                   CLK,
    input  logic                   RST,
    input  logic [`UART_IER_W-1:0] ier,
    input  uart_pkg::lsrT          lsr,
    input  logic                   thri,    // THR-empty latch
    input  logic                   RDA,
    input  logic                   CTI,     // Character timeout
    input  logic                   AFE,     // Auto flow control on
    input  uart_pkg::msrT          msr,
    output logic [`UART_IIR_W-1:0] iir,
    output logic                   INT
);

    logic srcRls;
    logic srcCti;
    logic srcRda;
    logic srcThr;
    logic srcMsr;
    logic ctsDelta;

    // Enabled sources
    assign srcRls = ier[2] &&
                    (lsr.f.overrun || lsr.f.parity || lsr.f.framing || lsr.f.brk);
    assign srcCti = ier[0] && CTI;
    assign srcRda = ier[0] && RDA;
    assign srcThr = ier[1] && thri;

    // CTS change belongs to the flow control logic while AFE is set
    assign ctsDelta = msr.f.dCts && !AFE;
    assign srcMsr   = ier[3] && (ctsDelta || msr.f.teri || msr.f.dDsr || msr.f.dDcd);

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            iir <= `UART_IIR_NONE;
        end else if (srcRls) begin
            iir <= `UART_IIR_RLS;       // Highest
        end else if (srcCti) begin
            iir <= `UART_IIR_CTI;       // Timeout ahead of plain data
        end else if (srcRda) begin
            iir <= `UART_IIR_RDA;
        end else if (srcThr) begin
            iir <= `UART_IIR_THR;
        end else if (srcMsr) begin
            iir <= `UART_IIR_MSR;       // Lowest
        end else begin
            iir <= `UART_IIR_NONE;
        end
    end

    assign INT = ~iir[0];               // Bit 0 low means pending

endmodule

`default_nettype wire

/* src/uart_intr_top.sv */
// UART interrupt and status top level
// Host decode, line and modem status, IIR priority logic
// and the registered read path

`default_nettype none

`include "uart_params.svh"

module uart_intr_top (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    WR,
    input  logic                    RD,
    input  logic [`UART_ADDR_W-1:0] ADDR,
    input  logic [`UART_DATA_W-1:0] WDATA,
    output logic [`UART_DATA_W-1:0] RDATA,
    input  logic                    CTSn,
    input  logic                    DSRn,
    input  logic                    RIn,
    input  logic                    DCDn,
    input  logic                    RDA,
    input  logic                    CTI,
    input  logic                    THREMPTY,
    input  logic                    AFE,
    input  logic                    ERROVR,
    input  logic                    ERRPAR,
    input  logic                    ERRFRM,
    input  logic                    ERRBRK,
    output logic                    INT
);

    logic [`UART_IER_W-1:0]  ier;
    logic                    thrWrite;
    logic                    iirRead;
    logic                    lsrRead;
    logic                    msrRead;
    logic                    rdEn;
    logic [`UART_ADDR_W-1:0] rdAddr;
    logic [`UART_DATA_W-1:0] lsr;       // Raw LSR byte
    logic [`UART_DATA_W-1:0] msr;       // Raw MSR byte
    logic                    thri;
    logic [`UART_IIR_W-1:0]  iir;

    uart_host_if uHostIf (
        .CLK(CLK), .RST(RST), .WR(WR), .RD(RD), .ADDR(ADDR), .WDATA(WDATA),
        .ier(ier), .thrWrite(thrWrite), .iirRead(iirRead), .lsrRead(lsrRead),
        .msrRead(msrRead), .rdEn(rdEn), .rdAddr(rdAddr)
    );

    uart_modem_status uModem (
        .CLK(CLK), .RST(RST), .CTSn(CTSn), .DSRn(DSRn), .RIn(RIn), .DCDn(DCDn),
        .msrRead(msrRead), .msr(msr)
    );

    uart_line_status uLine (
        .CLK(CLK), .RST(RST), .RDA(RDA), .THREMPTY(THREMPTY),
        .ERROVR(ERROVR), .ERRPAR(ERRPAR), .ERRFRM(ERRFRM), .ERRBRK(ERRBRK),
        .lsrRead(lsrRead), .thrWrite(thrWrite), .iirRead(iirRead), .iir(iir),
        .lsr(lsr), .thri(thri)
    );

    uart_interrupt uIntr (
        .CLK(CLK), .RST(RST), .ier(ier), .lsr(lsr), .thri(thri), .RDA(RDA),
        .CTI(CTI), .AFE(AFE), .msr(msr), .iir(iir), .INT(INT)
    );

    uart_read_mux uRdMux (
        .CLK(CLK), .RST(RST), .rdEn(rdEn), .rdAddr(rdAddr), .iirRead(iirRead),
        .lsrRead(lsrRead), .msrRead(msrRead), .ier(ier), .iir(iir), .lsr(lsr),
        .msr(msr), .RDATA(RDATA)
    );

endmodule

`default_nettype wire

/* src/uart_line_status.sv */
// UART line status
// Sticky receive error bits cleared by an LSR read, and the
// transmitter-holding-empty interrupt latch

`default_nettype none

`include "uart_params.svh"

module uart_line_status (
    input  logic                   CLK,
    input  logic                   RST,
    input  logic                   RDA,         // Receive data level
    input  logic                   THREMPTY,    // Holding register empty level
    input  logic                   ERROVR,      // One-cycle error pulses
    input  logic                   ERRPAR,
    input  logic                   ERRFRM,
    input  logic                   ERRBRK,
    input  logic                   lsrRead,
    input  logic                   thrWrite,
    input  logic                   iirRead,
    input  logic [`UART_IIR_W-1:0] iir,         // Code shown to this read
    output uart_pkg::lsrT          lsr,
    output logic                   thri
);

    logic overrun;
    logic parity;
    logic framing;
    logic brk;
    logic thrEmptyQ;    // THREMPTY one edge ago
    logic thriSet;
    logic thriClr;

    // Sticky errors, a pulse beats a same-cycle clear
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            overrun <= 1'b0;
            parity  <= 1'b0;
            framing <= 1'b0;
            brk     <= 1'b0;
        end else begin
            overrun <= ERROVR | (overrun & ~lsrRead);
            parity  <= ERRPAR | (parity & ~lsrRead);
            framing <= ERRFRM | (framing & ~lsrRead);
            brk     <= ERRBRK | (brk & ~lsrRead);
        end
    end

    assign thriSet = THREMPTY & ~thrEmptyQ;                             // Rising edge
    assign thriClr = thrWrite | (iirRead && (iir == `UART_IIR_THR));    // Only if THR shown

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            thrEmptyQ <= 1'b1;          // No edge out of reset
            thri      <= 1'b0;
        end else begin
            thrEmptyQ <= THREMPTY;
            thri      <= thriSet | (thri & ~thriClr);
        end
    end

    always_comb begin
        lsr.f.dataReady = RDA;
        lsr.f.overrun   = overrun;
        lsr.f.parity    = parity;
        lsr.f.framing   = framing;
        lsr.f.brk       = brk;
        lsr.f.thrEmpty  = THREMPTY;
        lsr.f.txEmpty   = THREMPTY;     // No shifter, follows THR
        lsr.f.fifoErr   = 1'b0;
    end

endmodule

`default_nettype wire

/* src/uart_modem_status.sv */
// UART modem status
// Two-flop synchronizers on the modem pins, change detection
// and the MSR delta bits, cleared by an MSR read

`default_nettype none

module uart_modem_status (
    input  logic          CLK,
    input  logic          RST,
    input  logic          CTSn,     // Active-low pins
    input  logic          DSRn,
    input  logic          RIn,
    input  logic          DCDn,
    input  logic          msrRead,  // Clears the deltas
    output uart_pkg::msrT msr
);

    // Pin order {dcd, ri, dsr, cts} as in the MSR upper nibble
    logic [3:0] pinSync1;   // First stage may go metastable
    logic [3:0] pinSync2;   // Stable current status
    logic [3:0] pinPrev;    // Status one edge ago
    logic [3:0] pinChg;
    logic       dCts;
    logic       dDsr;
    logic       teri;
    logic       dDcd;

    assign pinChg = pinSync2 ^ pinPrev;

    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            pinSync1 <= '0;                 // Pins idle high so all inactive
            pinSync2 <= '0;
            pinPrev  <= '0;
            dCts     <= 1'b0;
            dDsr     <= 1'b0;
            teri     <= 1'b0;
            dDcd     <= 1'b0;
        end else begin
            pinSync1 <= {~DCDn, ~RIn, ~DSRn, ~CTSn};
            pinSync2 <= pinSync1;
            pinPrev  <= pinSync2;
            // New change wins over a read clear
            dCts <= pinChg[0] | (dCts & ~msrRead);
            dDsr <= pinChg[1] | (dDsr & ~msrRead);
            teri <= (pinChg[2] & ~pinSync2[2]) | (teri & ~msrRead);  // RI released
            dDcd <= pinChg[3] | (dDcd & ~msrRead);
        end
    end

    always_comb begin
        msr.f.dCts = dCts;
        msr.f.dDsr = dDsr;
        msr.f.teri = teri;
        msr.f.dDcd = dDcd;
        msr.f.cts  = pinSync2[0];
        msr.f.dsr  = pinSync2[1];
        msr.f.ri   = pinSync2[2];
        msr.f.dcd  = pinSync2[3];
    end

endmodule

`default_nettype wire

/* src/uart_params.svh */
// UART interrupt and status block constants
// Register addresses, field widths, IIR codes and reset values

`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

`define UART_ADDR_W     3                   // Host address bits
`define UART_DATA_W     8                   // Register byte width
`define UART_IER_W      4                   // Implemented IER bits
`define UART_IIR_W      4                   // IIR code bits

`define UART_ADDR_THR   3'd0                // Transmit holding (write event only)
`define UART_ADDR_IER   3'd1                // Interrupt enable
`define UART_ADDR_IIR   3'd2                // Interrupt identification
`define UART_ADDR_LSR   3'd5                // Line status
`define UART_ADDR_MSR   3'd6                // Modem status

`define UART_IIR_NONE   4'b0001             // Nothing pending
`define UART_IIR_RLS    4'b0110             // Receiver line status
`define UART_IIR_CTI    4'b1100             // Character timeout
`define UART_IIR_RDA    4'b0100             // Receive data available
`define UART_IIR_THR    4'b0010             // Holding register empty
`define UART_IIR_MSR    4'b0000             // Modem status change
`define UART_IIR_FIFO   4'b1100             // Upper nibble, FIFOs present

`define UART_IER_RST    4'b0000             // All sources masked
`define UART_RDATA_RST  8'h00               // Read bus idle value

`endif

/* src/uart_pkg.sv */
// UART status register types
// LSR and MSR are read as whole bytes by the host and
// picked apart by field inside the interrupt logic

`default_nettype none

package uart_pkg;

    // Line status, bit 0 first from the bottom
    typedef struct packed {
        logic fifoErr;      // Bit 7, no FIFO errors here
        logic txEmpty;      // Transmitter idle
        logic thrEmpty;     // Holding register empty
        logic brk;          // Break seen
        logic framing;      // Framing error
        logic parity;       // Parity error
        logic overrun;      // Overrun error
        logic dataReady;    // Bit 0
    } lsrFieldsT;

    typedef union packed {
        logic [7:0] raw;    // Host view
        lsrFieldsT  f;      // Decoded view
    } lsrT;

    // Modem status, deltas in the low nibble
    typedef struct packed {
        logic dcd;          // Carrier detect
        logic ri;           // Ring indicator
        logic dsr;          // Data set ready
        logic cts;          // Clear to send
        logic dDcd;         // DCD changed
        logic teri;         // RI trailing edge
        logic dDsr;         // DSR changed
        logic dCts;         // CTS changed
    } msrFieldsT;

    typedef union packed {
        logic [7:0] raw;
        msrFieldsT  f;
    } msrT;

endpackage

`default_nettype wire

/* src/uart_read_mux.sv */
// UART read data path
// Picks the addressed register on a read pulse and holds the
// byte on RDATA until the next read

`default_nettype none

`include "uart_params.svh"

module uart_read_mux (
    input  logic                    CLK,
    input  logic                    RST,
    input  logic                    rdEn,       // Any read
    input  logic [`UART_ADDR_W-1:0] rdAddr,
    input  logic                    iirRead,
    input  logic                    lsrRead,
    input  logic                    msrRead,
    input  logic [`UART_IER_W-1:0]  ier,
    input  logic [`UART_IIR_W-1:0]  iir,
    input  uart_pkg::lsrT           lsr,
    input  uart_pkg::msrT           msr,
    output logic [`UART_DATA_W-1:0] RDATA
);

    logic [`UART_DATA_W-1:0] rdNext;

    always_comb begin
        if (iirRead) begin
            rdNext = {`UART_IIR_FIFO, iir};     // FIFOs reported present
        end else if (lsrRead) begin
            rdNext = lsr.raw;
        end else if (msrRead) begin
            rdNext = msr.raw;
        end else if (rdAddr == `UART_ADDR_IER) begin
            rdNext = {{(`UART_DATA_W - `UART_IER_W){1'b0}}, ier};
        end else begin
            rdNext = '0;                        // Unmapped address
        end
    end

    // Same edge as the read side effects, so old value is returned
    always_ff @(posedge CLK or posedge RST) begin
        if (RST) begin
            RDATA <= `UART_RDATA_RST;
        end else if (rdEn) begin
            RDATA <= rdNext;
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+src
src/uart_pkg.sv
src/uart_host_if.sv
src/uart_modem_status.sv
src/uart_line_status.sv
src/uart_interrupt.sv
src/uart_read_mux.sv
src/uart_intr_top.sv
bench/uart_intr_chk.sv
bench/uart_intr_tb.sv
